// File: common/opl_pkg.sv
////////////////////////////////////////
// opl host package
// widths, fifo sizing, timer constants and
// status/control bit positions
////////////////////////////////////////

package opl_pkg;

    // host data, register address, register value, status byte
    localparam int REG_DATA_WIDTH = 8;
    localparam int REG_FILE_DEPTH = 2 ** (REG_DATA_WIDTH + 1);  // two banks

    // cdc fifo
    localparam int FIFO_LG_DEPTH = 4;
    localparam int FIFO_DEPTH = 2 ** FIFO_LG_DEPTH;
    localparam int FIFO_WIDTH = 2 + REG_DATA_WIDTH;  // host address + data byte

    // timer prescalers, scaled down from the chip's 80us/320us ticks
    localparam int TIMER1_TICK_CYCLES = 8;
    localparam int TIMER2_TICK_MULT = 4;
    localparam int TIMER1_PRESCALE_WIDTH = $clog2(TIMER1_TICK_CYCLES);
    localparam int TIMER2_PRESCALE_WIDTH = $clog2(TIMER2_TICK_MULT);

    // timer registers, bank 0
    localparam logic [REG_DATA_WIDTH-1:0] TIMER1_REG_ADDR = 8'h02;
    localparam logic [REG_DATA_WIDTH-1:0] TIMER2_REG_ADDR = 8'h03;
    localparam logic [REG_DATA_WIDTH-1:0] TIMER_CTRL_REG_ADDR = 8'h04;

    // status byte
    localparam int STATUS_IRQ_BIT = 7;
    localparam int STATUS_T1_BIT = 6;
    localparam int STATUS_T2_BIT = 5;

    // timer control register
    localparam int CTRL_IRQ_RESET_BIT = 7;
    localparam int CTRL_T1_MASK_BIT = 6;
    localparam int CTRL_T2_MASK_BIT = 5;
    localparam int CTRL_T2_START_BIT = 1;
    localparam int CTRL_T1_START_BIT = 0;

endpackage

// File: common/reg_wr_if.sv
////////////////////////////////////////
// register write event
// one valid pulse per data write
////////////////////////////////////////

interface reg_wr_if;

    logic                               valid;    // one-cycle write strobe
    logic                               bank;     // 0 or 1
    logic [opl_pkg::REG_DATA_WIDTH-1:0] address;  // register within bank
    logic [opl_pkg::REG_DATA_WIDTH-1:0] data;

    // driven by the host front end
    modport source (
        output valid,
        output bank,
        output address,
        output data
    );

    // register file and timers
    modport sink (
        input valid,
        input bank,
        input address,
        input data
    );

endinterface

// File: design/host_if/async_fifo.sv
////////////////////////////////////////
// dual-clock fifo
// gray pointers, two-flop pointer sync
////////////////////////////////////////

module async_fifo (
    // write side
    input  logic                           i_wclk,
    input  logic                           i_wr_reset,
    input  logic                           i_wr,
    input  logic [opl_pkg::FIFO_WIDTH-1:0] i_wr_data,
    output logic                           o_wr_full,
    // read side
    input  logic                           i_rclk,
    input  logic                           i_rd_reset,
    input  logic                           i_rd,
    output logic [opl_pkg::FIFO_WIDTH-1:0] o_rd_data,
    output logic                           o_rd_empty
);

    localparam int LG = opl_pkg::FIFO_LG_DEPTH;

    logic [opl_pkg::FIFO_WIDTH-1:0] mem [0:opl_pkg::FIFO_DEPTH-1];

    // pointers carry one extra bit for wrap
    logic [LG:0] wbin;
    logic [LG:0] wbin_next;
    logic [LG:0] wgray;
    logic [LG:0] rbin;
    logic [LG:0] rbin_next;
    logic [LG:0] rgray;
    logic [LG:0] rq1_wgray;  // write pointer in read domain
    logic [LG:0] rq2_wgray;
    logic [LG:0] wq1_rgray;  // read pointer in write domain
    logic [LG:0] wq2_rgray;
    logic        push;
    logic        pop;

    // write domain
    assign push = i_wr && !o_wr_full;
    assign wbin_next = wbin + 1'b1;

    always_ff @(posedge i_wclk) begin
        if (push) begin
            mem[wbin[LG-1:0]] <= i_wr_data;
        end
    end

    always_ff @(posedge i_wclk) begin
        if (i_wr_reset) begin
            wbin      <= '0;
            wgray     <= '0;
            wq1_rgray <= '0;
            wq2_rgray <= '0;
        end else begin
            wq1_rgray <= rgray;
            wq2_rgray <= wq1_rgray;
            if (push) begin
                wbin  <= wbin_next;
                wgray <= wbin_next ^ (wbin_next >> 1);  // bin to gray
            end
        end
    end

    // full when pointers differ only in the two msbs of gray
    assign o_wr_full = (wgray == {~wq2_rgray[LG:LG-1], wq2_rgray[LG-2:0]});

    // read domain
    assign pop = i_rd && !o_rd_empty;
    assign rbin_next = rbin + 1'b1;

    always_ff @(posedge i_rclk) begin
        if (i_rd_reset) begin
            rbin      <= '0;
            rgray     <= '0;
            rq1_wgray <= '0;
            rq2_wgray <= '0;
        end else begin
            rq1_wgray <= wgray;
            rq2_wgray <= rq1_wgray;
            if (pop) begin
                rbin  <= rbin_next;
                rgray <= rbin_next ^ (rbin_next >> 1);
            end
        end
    end

    assign o_rd_empty = (rgray == rq2_wgray);
    assign o_rd_data  = mem[rbin[LG-1:0]];  // fall-through

endmodule

// File: design/host_if/host_if.sv
////////////////////////////////////////
// host bus front end
// host writes cross to core via fifo, get
// decoded into register writes; status goes back
////////////////////////////////////////

module host_if (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               i_clk_host,
    input  logic                               i_cs_n,
    input  logic                               i_rd_n,     // no effect, dout always status
    input  logic                               i_wr_n,
    input  logic [1:0]                         i_address,
    input  logic [opl_pkg::REG_DATA_WIDTH-1:0] i_din,
    input  logic [opl_pkg::REG_DATA_WIDTH-1:0] i_status,   // core domain
    output logic [opl_pkg::REG_DATA_WIDTH-1:0] o_dout,     // host domain
    reg_wr_if.source                           o_reg_wr
);

    logic [1:0]                         host_reset_sync;  // core reset into host domain
    logic                               host_reset;
    logic [1:0]                         core_hreset_sync; // host reset back in core
    logic                               hreset_seen;
    logic                               fifo_rd_reset;
    logic                               wr_level;
    logic                               wr_p1;
    logic                               fifo_push;
    logic                               fifo_empty;
    logic [1:0]                         fifo_addr;
    logic [opl_pkg::REG_DATA_WIDTH-1:0] fifo_data;
    logic [opl_pkg::REG_DATA_WIDTH-1:0] status_meta;

    always_ff @(posedge i_clk_host) begin
        host_reset_sync <= {host_reset_sync[0], reset};
    end
    assign host_reset = host_reset_sync[1];

    always_ff @(posedge clk) begin
        core_hreset_sync <= {core_hreset_sync[0], host_reset};
    end

    // fifo read side held until the host side reset has come and gone
    // so it never picks up a stale write pointer
    always_ff @(posedge clk) begin
        if (reset) begin
            fifo_rd_reset <= 1'b1;
            hreset_seen   <= 1'b0;
        end else if (core_hreset_sync[1]) begin
            hreset_seen <= 1'b1;
        end else if (hreset_seen) begin
            fifo_rd_reset <= 1'b0;  // write pointer is zero by now
        end
    end

    assign wr_level = !i_cs_n && !i_wr_n;

    always_ff @(posedge i_clk_host) begin
        if (host_reset) begin
            wr_p1 <= 1'b0;
        end else begin
            wr_p1 <= wr_level;
        end
    end
    assign fifo_push = wr_level && !wr_p1;  // first cycle of the strobe only

    async_fifo u_fifo (
        .i_wclk     (i_clk_host),
        .i_wr_reset (host_reset),
        .i_wr       (fifo_push),
        .i_wr_data  ({i_address, i_din}),
        .o_wr_full  (),                     // host paces itself
        .i_rclk     (clk),
        .i_rd_reset (fifo_rd_reset),
        .i_rd       (!fifo_empty),          // drain every cycle
        .o_rd_data  ({fifo_addr, fifo_data}),
        .o_rd_empty (fifo_empty)
    );

    // address writes on even ports, data writes on odd ports
    always_ff @(posedge clk) begin
        if (reset) begin
            o_reg_wr.valid   <= 1'b0;
            o_reg_wr.bank    <= 1'b0;
            o_reg_wr.address <= '0;
            o_reg_wr.data    <= '0;
        end else begin
            o_reg_wr.valid <= 1'b0;
            if (!fifo_empty) begin
                if (!fifo_addr[0]) begin
                    o_reg_wr.bank    <= fifo_addr[1];  // port 2 selects bank 1
                    o_reg_wr.address <= fifo_data;
                end else begin
                    o_reg_wr.data  <= fifo_data;       // keeps last bank/address
                    o_reg_wr.valid <= 1'b1;
                end
            end
        end
    end

    // status bits are independent flags, per-bit sync is fine
    always_ff @(posedge i_clk_host) begin
        status_meta <= i_status;
        o_dout      <= status_meta;
    end

endmodule

// File: design/reg_file.sv
////////////////////////////////////////
// two-bank register file
// 2 x 256 bytes, written by register
// write events, one-cycle lookup port
////////////////////////////////////////

module reg_file (
    input  logic                               clk,
    input  logic                               i_lookup_bank,
    input  logic [opl_pkg::REG_DATA_WIDTH-1:0] i_lookup_addr,
    output logic [opl_pkg::REG_DATA_WIDTH-1:0] o_lookup_data,
    reg_wr_if.sink                             i_reg_wr
);

    // {bank, address} index
    logic [opl_pkg::REG_DATA_WIDTH-1:0] mem [0:opl_pkg::REG_FILE_DEPTH-1];

    logic [opl_pkg::REG_DATA_WIDTH:0] wr_index;
    logic [opl_pkg::REG_DATA_WIDTH:0] rd_index;

    assign wr_index = {i_reg_wr.bank, i_reg_wr.address};
    assign rd_index = {i_lookup_bank, i_lookup_addr};

    always_ff @(posedge clk) begin
        if (i_reg_wr.valid) begin
            mem[wr_index] <= i_reg_wr.data;
        end
    end

    // same-cycle hit sees the old value
    always_ff @(posedge clk) begin
        o_lookup_data <= mem[rd_index];
    end

endmodule

// File: design/timer_block.sv
////////////////////////////////////////
// opl timers 1 and 2
// preload/control decode, prescaled up
// counters, overflow flags, status byte
////////////////////////////////////////

module timer_block (
    input  logic                               clk,
    input  logic                               reset,
    output logic [opl_pkg::REG_DATA_WIDTH-1:0] o_status,
    reg_wr_if.sink                             i_reg_wr
);

    logic [opl_pkg::TIMER1_PRESCALE_WIDTH-1:0] t1_prescale;
    logic [opl_pkg::TIMER2_PRESCALE_WIDTH-1:0] t2_prescale;  // counts t1 ticks

    // index 0 is timer 1, index 1 is timer 2
    logic [opl_pkg::REG_DATA_WIDTH-1:0] preload [2];
    logic [opl_pkg::REG_DATA_WIDTH-1:0] count [2];
    logic [1:0]                         tick;
    logic [1:0]                         start;
    logic [1:0]                         mask;
    logic [1:0]                         flag;
    logic [1:0]                         preload_wr;
    logic [1:0]                         new_start;
    logic [1:0]                         new_mask;
    logic                               bank0_wr;
    logic                               ctrl_wr;
    logic                               irq_reset;

    // free running prescalers
    assign tick[0] = (t1_prescale == opl_pkg::TIMER1_TICK_CYCLES - 1);
    assign tick[1] = tick[0] && (t2_prescale == opl_pkg::TIMER2_TICK_MULT - 1);

    always_ff @(posedge clk) begin
        if (reset) begin
            t1_prescale <= '0;
            t2_prescale <= '0;
        end else begin
            t1_prescale <= tick[0] ? '0 : t1_prescale + 1'b1;
            if (tick[0]) begin
                t2_prescale <= tick[1] ? '0 : t2_prescale + 1'b1;
            end
        end
    end

    // register decode, bank 0 only
    assign bank0_wr      = i_reg_wr.valid && !i_reg_wr.bank;
    assign preload_wr[0] = bank0_wr && (i_reg_wr.address == opl_pkg::TIMER1_REG_ADDR);
    assign preload_wr[1] = bank0_wr && (i_reg_wr.address == opl_pkg::TIMER2_REG_ADDR);
    assign ctrl_wr       = bank0_wr && (i_reg_wr.address == opl_pkg::TIMER_CTRL_REG_ADDR);
    assign irq_reset     = i_reg_wr.data[opl_pkg::CTRL_IRQ_RESET_BIT];  // other bits ignored

    assign new_start[0] = i_reg_wr.data[opl_pkg::CTRL_T1_START_BIT];
    assign new_start[1] = i_reg_wr.data[opl_pkg::CTRL_T2_START_BIT];
    assign new_mask[0]  = i_reg_wr.data[opl_pkg::CTRL_T1_MASK_BIT];
    assign new_mask[1]  = i_reg_wr.data[opl_pkg::CTRL_T2_MASK_BIT];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 2; i++) begin
                preload[i] <= '0;
                count[i]   <= '0;
            end
            start <= '0;  // both timers stopped
            mask  <= '0;
            flag  <= '0;
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (preload_wr[i]) begin
                    preload[i] <= i_reg_wr.data;
                end

                // count up, reload on wrap past 0xff
                if (start[i] && tick[i]) begin
                    if (&count[i]) begin
                        count[i] <= preload[i];
                        if (!mask[i]) begin
                            flag[i] <= 1'b1;
                        end
                    end else begin
                        count[i] <= count[i] + 1'b1;
                    end
                end

                if (ctrl_wr && !irq_reset) begin
                    start[i] <= new_start[i];
                    mask[i]  <= new_mask[i];
                    if (new_start[i] && !start[i]) begin
                        count[i] <= preload[i];  // load on start edge
                    end
                end
            end

            if (ctrl_wr && irq_reset) begin
                flag <= '0;  // wins over a same-cycle overflow
            end
        end
    end

    always_comb begin
        o_status = '0;
        o_status[opl_pkg::STATUS_IRQ_BIT] = |flag;
        o_status[opl_pkg::STATUS_T1_BIT]  = flag[0];
        o_status[opl_pkg::STATUS_T2_BIT]  = flag[1];
    end

endmodule

// File: design/opl_host_top.sv
////////////////////////////////////////
// opl host subsystem top
// host interface, register file, timers
////////////////////////////////////////

module opl_host_top (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               i_clk_host,
    // host bus
    input  logic                               i_cs_n,
    input  logic                               i_rd_n,
    input  logic                               i_wr_n,
    input  logic [1:0]                         i_address,
    input  logic [opl_pkg::REG_DATA_WIDTH-1:0] i_din,
    output logic [opl_pkg::REG_DATA_WIDTH-1:0] o_dout,
    // synthesis engine lookup
    input  logic                               i_lookup_bank,
    input  logic [opl_pkg::REG_DATA_WIDTH-1:0] i_lookup_addr,
    output logic [opl_pkg::REG_DATA_WIDTH-1:0] o_lookup_data
);

    logic [opl_pkg::REG_DATA_WIDTH-1:0] status;  // core domain

    reg_wr_if reg_wr ();

    host_if u_host_if (
        .clk        (clk),
        .reset      (reset),
        .i_clk_host (i_clk_host),
        .i_cs_n     (i_cs_n),
        .i_rd_n     (i_rd_n),
        .i_wr_n     (i_wr_n),
        .i_address  (i_address),
        .i_din      (i_din),
        .i_status   (status),
        .o_dout     (o_dout),
        .o_reg_wr   (reg_wr.source)
    );

    reg_file u_reg_file (
        .clk           (clk),
        .i_lookup_bank (i_lookup_bank),
        .i_lookup_addr (i_lookup_addr),
        .o_lookup_data (o_lookup_data),
        .i_reg_wr      (reg_wr.sink)
    );

    timer_block u_timer_block (
        .clk      (clk),
        .reset    (reset),
        .o_status (status),
        .i_reg_wr (reg_wr.sink)
    );

endmodule

// File: testbench/opl_host_checker.sv
////////////////////////////////////////
// opl host checker
// compares lookup data and status byte
// against the testbench reference model
////////////////////////////////////////

module opl_host_checker (
    input  logic       clk,
    input  logic       i_clk_host,
    input  logic       i_lookup_check,    // lookup issued this cycle
    input  logic       i_lookup_bank,
    input  logic [7:0] i_lookup_addr,
    input  logic [7:0] i_lookup_exp,
    input  logic [7:0] i_lookup_data,
    input  logic       i_status_check,    // settled point, host domain
    input  logic [7:0] i_status_exp,
    input  logic [7:0] i_dout,
    output int         o_mismatch_count
);
    timeunit 1ns;
    timeprecision 1ps;

    logic       pending = 1'b0;           // lookup waiting for its data
    logic       pending_bank;
    logic [7:0] pending_addr;
    logic [7:0] pending_exp;
    int         lookup_errors = 0;
    int         status_errors = 0;

    // data shows one clk after the lookup
    always @(posedge clk) begin
        if (pending && i_lookup_data !== pending_exp) begin
            $display("MISMATCH %0t o_lookup_data bank %0d addr 0x%02h expected 0x%02h actual 0x%02h",
                     $time, pending_bank, pending_addr, pending_exp, i_lookup_data);
            lookup_errors <= lookup_errors + 1;
        end
        pending      <= i_lookup_check;
        pending_bank <= i_lookup_bank;
        pending_addr <= i_lookup_addr;
        pending_exp  <= i_lookup_exp;
    end

    // sampled every host cycle while the window is open
    always @(posedge i_clk_host) begin
        if (i_status_check && i_dout !== i_status_exp) begin
            $display("MISMATCH %0t o_dout expected 0x%02h actual 0x%02h",
                     $time, i_status_exp, i_dout);
            status_errors <= status_errors + 1;
        end
    end

    assign o_mismatch_count = lookup_errors + status_errors;

endmodule

// File: testbench/opl_host_tb.sv
////////////////////////////////////////
// opl host testbench
// clocks, reset, host bus stimulus and
// reference model for lookups and status
////////////////////////////////////////

module opl_host_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int WAIT_CAP   = 2000;  // cycles per wait loop
    localparam int NUM_RANDOM = 12;    // writes per random pass

    logic       clk = 1'b0;
    logic       clk_host = 1'b0;
    logic       reset;
    logic       cs_n;
    logic       rd_n;
    logic       wr_n;
    logic [1:0] address;
    logic [7:0] din;
    logic [7:0] dout;
    logic       lookup_bank;
    logic [7:0] lookup_addr;
    logic [7:0] lookup_data;
    logic       lookup_check;              // to checker
    logic [7:0] lookup_exp;
    logic       status_check;
    logic [7:0] status_exp;
    int         mismatches;                // from checker
    int         timeouts;

    // reference model state
    logic [7:0] shadow_mem [0:511];        // {bank, address}
    logic       sel_bank;                  // last address write
    logic [7:0] sel_addr;
    logic [1:0] t_start;                   // [0] timer 1, [1] timer 2
    logic [1:0] t_mask;
    logic [1:0] t_flag;

    always #20 clk = ~clk;                 // core, 40 ns
    always #26 clk_host = ~clk_host;       // host, 52 ns, unrelated

    opl_host_top UUT (
        .clk           (clk),
        .reset         (reset),
        .i_clk_host    (clk_host),
        .i_cs_n        (cs_n),
        .i_rd_n        (rd_n),
        .i_wr_n        (wr_n),
        .i_address     (address),
        .i_din         (din),
        .o_dout        (dout),
        .i_lookup_bank (lookup_bank),
        .i_lookup_addr (lookup_addr),
        .o_lookup_data (lookup_data)
    );

    opl_host_checker u_checker (
        .clk              (clk),
        .i_clk_host       (clk_host),
        .i_lookup_check   (lookup_check),
        .i_lookup_bank    (lookup_bank),
        .i_lookup_addr    (lookup_addr),
        .i_lookup_exp     (lookup_exp),
        .i_lookup_data    (lookup_data),
        .i_status_check   (status_check),
        .i_status_exp     (status_exp),
        .i_dout           (dout),
        .o_mismatch_count (mismatches)
    );

    function automatic logic [7:0] expected_lookup(input logic bank, input logic [7:0] addr);
        return shadow_mem[{bank, addr}];
    endfunction

    function automatic logic [7:0] expected_status();
        logic [7:0] s;
        s = 8'h00;                         // unused bits read 0
        s[opl_pkg::STATUS_IRQ_BIT] = |t_flag;
        s[opl_pkg::STATUS_T1_BIT]  = t_flag[0];
        s[opl_pkg::STATUS_T2_BIT]  = t_flag[1];
        return s;
    endfunction

    // even port selects, odd port writes to the selected register
    function automatic void model_write(input logic [1:0] port, input logic [7:0] data);
        if (!port[0]) begin
            sel_bank = port[1];
            sel_addr = data;
        end else begin
            shadow_mem[{sel_bank, sel_addr}] = data;
            if (!sel_bank && sel_addr == 8'h04) begin
                if (data[7]) begin
                    t_flag = 2'b00;        // irq reset, rest ignored
                end else begin
                    t_start = {data[1], data[0]};
                    t_mask  = {data[5], data[6]};
                end
            end
        end
    endfunction

    // a started timer always overflows, flag only if unmasked
    function automatic void apply_overflow_rule();
        t_flag = t_flag | (t_start & ~t_mask);
    endfunction

    task automatic host_write(input logic [1:0] port, input logic [7:0] data, input int hold);
        int n;
        n = (hold > 0) ? hold : $urandom_range(1, 3);
        @(posedge clk_host);
        #2;
        address = port;
        din     = data;
        cs_n    = 1'b0;
        wr_n    = 1'b0;
        repeat (n) begin
            @(posedge clk_host);
            #2;
            din = ~data;                   // a push per level cycle would take this
        end
        cs_n = 1'b1;
        wr_n = 1'b1;
        repeat (4) @(posedge clk_host);    // gap between writes
        model_write(port, data);
    endtask

    task automatic reg_write(input logic bank, input logic [7:0] addr, input logic [7:0] data);
        host_write({bank, 1'b0}, addr, 0);
        host_write({bank, 1'b1}, data, 0);
    endtask

    task automatic lookup(input logic bank, input logic [7:0] addr);
        @(posedge clk);
        #2;
        lookup_bank  = bank;
        lookup_addr  = addr;
        lookup_exp   = expected_lookup(bank, addr);
        lookup_check = 1'b1;
        @(posedge clk);
        #2;
        lookup_check = 1'b0;
        @(posedge clk);                    // checker compares here
    endtask

    task automatic set_status_watch(input logic on);
        @(posedge clk_host);
        #2;
        status_exp   = expected_status();
        status_check = on;
    endtask

    task automatic check_status();
        set_status_watch(1'b1);
        set_status_watch(1'b0);
    endtask

    task automatic wait_status(input logic [7:0] exp, input int cap, input string what);
        int n;
        n = 0;
        while (dout !== exp && n < cap) begin
            @(posedge clk_host);
            n++;
        end
        if (dout !== exp) begin
            $display("%0t: status never reached 0x%02h after %s", $time, exp, what);
            timeouts++;
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #2;
        reset = 1'b1;
        repeat (2) @(posedge clk);
        #2;
        reset    = 1'b0;
        sel_bank = 1'b0;                   // decoder state clears, memory kept
        sel_addr = 8'h00;
        t_start  = 2'b00;
        t_mask   = 2'b00;
        t_flag   = 2'b00;
        repeat (10) @(posedge clk_host);   // host side reset sync
    endtask

    task automatic random_write_pass();
        logic       banks [NUM_RANDOM];
        logic [7:0] addrs [NUM_RANDOM];
        for (int i = 0; i < NUM_RANDOM; i++) begin
            banks[i] = 1'($urandom_range(0, 1));
            addrs[i] = 8'($urandom_range(8'h10, 8'hef));  // clear of timer regs
            reg_write(banks[i], addrs[i], 8'($urandom_range(0, 255)));
        end
        repeat (100) @(posedge clk);
        for (int i = 0; i < NUM_RANDOM; i++) begin
            lookup(banks[i], addrs[i]);
        end
    endtask

    initial begin
        void'($urandom(33965));
        $timeformat(-9, 0, " ns", 10);
        reset        = 1'b1;
        cs_n         = 1'b1;
        rd_n         = 1'b1;
        wr_n         = 1'b1;
        address      = 2'd0;
        din          = 8'h00;
        lookup_bank  = 1'b0;
        lookup_addr  = 8'h00;
        lookup_check = 1'b0;
        lookup_exp   = 8'h00;
        status_check = 1'b0;
        status_exp   = 8'h00;
        timeouts     = 0;
        sel_bank     = 1'b0;
        sel_addr     = 8'h00;
        t_start      = 2'b00;
        t_mask       = 2'b00;
        t_flag       = 2'b00;
        repeat (2) @(posedge clk);
        #2;
        reset = 1'b0;
        repeat (10) @(posedge clk_host);
        wait_status(expected_status(), WAIT_CAP, "power-up reset");
        set_status_watch(1'b1);            // no timer runs in the first passes

        random_write_pass();

        // held strobe counts once
        reg_write(1'b1, 8'hf0, 8'h11);
        reg_write(1'b1, 8'hf2, 8'h22);
        host_write(2'd2, 8'hf1, 0);
        host_write(2'd3, 8'h5a, 3);
        reg_write(1'b1, 8'hf3, 8'ha5);
        repeat (100) @(posedge clk);
        for (int a = 8'hf0; a <= 8'hf3; a++) begin
            lookup(1'b1, 8'(a));
        end

        // sticky address, three data writes
        reg_write(1'b0, 8'hf4, 8'h33);
        reg_write(1'b0, 8'hf6, 8'h44);
        host_write(2'd0, 8'hf5, 0);
        host_write(2'd1, 8'ha1, 0);
        host_write(2'd1, 8'hb2, 0);
        host_write(2'd1, 8'hc3, 0);
        repeat (100) @(posedge clk);
        for (int a = 8'hf4; a <= 8'hf6; a++) begin
            lookup(1'b0, 8'(a));
        end
        set_status_watch(1'b0);

        // timer 1 overflow, then irq reset
        reg_write(1'b0, 8'h02, 8'hf0);
        reg_write(1'b0, 8'h04, 8'h01);
        apply_overflow_rule();
        wait_status(expected_status(), WAIT_CAP, "timer 1 start");
        check_status();
        reg_write(1'b0, 8'h04, 8'h80);
        wait_status(expected_status(), 20, "irq reset");
        check_status();

        // timer 2 masked, then unmasked
        reg_write(1'b0, 8'h04, 8'h00);     // stop timer 1
        reg_write(1'b0, 8'h04, 8'h80);     // drop any late flag
        wait_status(expected_status(), WAIT_CAP, "timer stop");
        reg_write(1'b0, 8'h03, 8'hfc);
        reg_write(1'b0, 8'h04, 8'h22);     // t2 start, t2 masked
        set_status_watch(1'b1);
        repeat (1000) @(posedge clk);
        set_status_watch(1'b0);
        reg_write(1'b0, 8'h04, 8'h02);     // unmask, start kept
        apply_overflow_rule();
        wait_status(expected_status(), WAIT_CAP, "timer 2 unmask");
        check_status();

        // mid-run reset
        apply_reset();
        wait_status(expected_status(), WAIT_CAP, "mid-run reset");
        set_status_watch(1'b1);
        random_write_pass();
        set_status_watch(1'b0);

        repeat (5) @(posedge clk_host);
        $display("error counts: %0d mismatches, %0d timeouts", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: opl_host_top.f
common/opl_pkg.sv
common/reg_wr_if.sv
design/host_if/async_fifo.sv
design/host_if/host_if.sv
design/reg_file.sv
design/timer_block.sv
design/opl_host_top.sv
testbench/opl_host_checker.sv
testbench/opl_host_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = opl_host_tb
FILELIST = opl_host_top.f
OBJ_DIR  = obj_dir

.PHONY: compile run clean

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# echo the output, status comes from the search
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "all tests passed"

clean:
	rm -rf $(OBJ_DIR)
